// ==== all.f ====
verilog/uart_pkg.sv
verilog/video_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/frame_uploader.sv
verilog/image_select.sv
verilog/status_display.sv
verilog/camera_link_top.sv
dv/tb_camera_link.sv

// ==== dv/tb_camera_link.sv ====
// Testbench for the camera link top level
// Drives host bytes over UART, display and upload modes, frame-buffer
// words and burst keys, and checks against a local model
`timescale 1ns/1ps
`default_nettype none

module tb_camera_link
  import uart_pkg::*;
  import video_pkg::*;
();

  localparam int burst_len = 16;
  localparam int bit_limit = 3 * clks_per_bit;

  // ====================
  // DUT signals
  // ====================
  logic       CLOCK_50;
  logic       DLY_RST_0;
  logic       uart_rxd;
  logic       uart_txd;
  logic       start_n;
  logic       stop_n;
  logic       upload_mode;
  logic       grey_mode;
  tx_pixel_t  tx_pixel;
  logic       tx_pixel_req;
  logic       store_valid;
  buf_word_t  store_data;
  buf_word_t  read_data;
  buf_addr_t  read_base;
  logic       disp_restart_n;
  color_t     vga_r;
  color_t     vga_g;
  color_t     vga_b;
  seg_t       hex0;
  seg_t       hex1;
  seg_t       hex2;
  seg_t       hex3;
  seg_t       hex4;
  seg_t       hex5;

  // Model state
  tx_pixel_t  pix_mem [64];
  int         pix_idx = 0;
  int         restart_cnt = 0;
  int         store_cnt = 0;
  buf_word_t  store_seen;
  int         exp_changes = 0;
  logic [7:0] img_exp = 8'h00;

  // Active-low hex font indexed by digit
  seg_t seg_tab [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                         7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};

  camera_link_top #(
    .frame_bytes(burst_len)
  ) u_camera_link_top (
    .CLOCK_50      (CLOCK_50),
    .DLY_RST_0     (DLY_RST_0),
    .uart_rxd      (uart_rxd),
    .uart_txd      (uart_txd),
    .start_n       (start_n),
    .stop_n        (stop_n),
    .upload_mode   (upload_mode),
    .grey_mode     (grey_mode),
    .tx_pixel      (tx_pixel),
    .tx_pixel_req  (tx_pixel_req),
    .store_valid   (store_valid),
    .store_data    (store_data),
    .read_data     (read_data),
    .read_base     (read_base),
    .disp_restart_n(disp_restart_n),
    .vga_r         (vga_r),
    .vga_g         (vga_g),
    .vga_b         (vga_b),
    .hex0          (hex0),
    .hex1          (hex1),
    .hex2          (hex2),
    .hex3          (hex3),
    .hex4          (hex4),
    .hex5          (hex5)
  );

  always #10 CLOCK_50 = ~CLOCK_50;

  // Pixel source advances on each request
  always @(posedge CLOCK_50) begin
    if (DLY_RST_0 && tx_pixel_req) begin
      pix_idx  <= pix_idx + 1;
      tx_pixel <= pix_mem[pix_idx + 1];
    end
  end

  // Restart low cycles and store strobes
  always @(posedge CLOCK_50) begin
    if (DLY_RST_0 && !disp_restart_n) begin
      restart_cnt <= restart_cnt + 1;
    end
    if (DLY_RST_0 && store_valid) begin
      store_cnt  <= store_cnt + 1;
      store_seen <= store_data;
    end
  end

  // ====================
  // Helpers
  // ====================
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  // Read base rule for a 23-bit word address
  function automatic logic [31:0] base_of(input logic grey, input logic [7:0] idx);
    if (grey) begin
      return 32'(live_base);
    end
    return (32'(store_base) + 32'(image_stride) * 32'(idx)) & 32'h007F_FFFF;
  endfunction

  // Host byte onto uart_rxd as start, 8 data LSB first and stop
  task automatic send_rx(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge CLOCK_50);
      uart_rxd <= frame[i];
      repeat (clks_per_bit - 1) @(posedge CLOCK_50);
    end
  endtask

  // Decode one byte from uart_txd sampled at bit centres
  task automatic recv_tx(input int limit, input logic must, output logic found,
                         output logic [7:0] b);
    int n;
    found = 1'b0;
    b = 8'h00;
    n = 0;
    while (uart_txd !== 1'b0 && n < limit) begin
      @(negedge CLOCK_50);
      n++;
    end
    if (uart_txd !== 1'b0) begin
      if (must) begin
        abort_run("Timeout waiting for a start bit on uart_txd");
      end
    end else begin
      repeat (clks_per_bit / 2) @(negedge CLOCK_50);
      check("uart_txd start bit", uart_txd, 1'b0);
      for (int i = 0; i < 8; i++) begin
        repeat (clks_per_bit) @(negedge CLOCK_50);
        b[i] = uart_txd;
      end
      repeat (clks_per_bit) @(negedge CLOCK_50);
      check("uart_txd stop bit", uart_txd, 1'b1);
      found = 1'b1;
    end
  endtask

  task automatic wait_hex4(input seg_t want, input string why);
    int n;
    n = 0;
    while (hex4 !== want && n < 20 * clks_per_bit) begin
      @(negedge CLOCK_50);
      n++;
    end
    if (hex4 !== want) begin
      abort_run(why);
    end
  endtask

  task automatic pulse_key(input logic is_stop);
    @(posedge CLOCK_50);
    if (is_stop) stop_n <= 1'b0;
    else start_n <= 1'b0;
    @(posedge CLOCK_50);
    stop_n  <= 1'b1;
    start_n <= 1'b1;
  endtask

  task automatic set_grey(input logic val);
    if (grey_mode !== val) begin
      @(posedge CLOCK_50);
      grey_mode <= val;
      exp_changes++;
      repeat (3) @(posedge CLOCK_50);
    end
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    logic [7:0]  b;
    int          cnt_prev;
    int          n;
    int          pix_base;
    logic        found;

    void'($urandom(32'hd7681bf7));
    for (int i = 0; i < 64; i++) begin
      pix_mem[i] = tx_pixel_t'($urandom);
    end
    CLOCK_50    = 1'b0;
    DLY_RST_0   = 1'b0;
    uart_rxd    = 1'b1;
    start_n     = 1'b1;
    stop_n      = 1'b1;
    upload_mode = 1'b0;
    grey_mode   = 1'b0;
    read_data   = '0;
    tx_pixel    = pix_mem[0];
    repeat (2) @(posedge CLOCK_50);
    DLY_RST_0 <= 1'b1;
    repeat (2) @(negedge CLOCK_50);

    // Idle levels after reset
    check("uart_txd", uart_txd, 1'b1);
    check("store_valid", store_valid, 1'b0);
    check("tx_pixel_req", tx_pixel_req, 1'b0);
    check("disp_restart_n", disp_restart_n, 1'b1);
    check("hex4", hex4, seg_tab[0]);
    check("hex5", hex5, seg_tab[0]);

    // Image selection with random grey toggles between bytes
    for (int k = 0; k < 8; k++) begin
      if ($urandom % 2) begin
        set_grey(!grey_mode);
      end
      b = 8'($urandom);
      send_rx(b);
      if (b != img_exp) exp_changes++;
      img_exp = b;
      repeat (4) @(posedge CLOCK_50);
      @(negedge CLOCK_50);
      check("read_base", read_base, base_of(grey_mode, b));
      check("hex0", hex0, seg_tab[b[3:0]]);
      check("hex1", hex1, seg_tab[b[7:4]]);
      check("hex2", hex2, seg_tab[b[3:0]]);
      check("hex3", hex3, seg_tab[b[7:4]]);
      check("hex5", hex5, seg_tab[0]);
    end

    // Upload routing leaves the index alone
    @(posedge CLOCK_50);
    upload_mode <= 1'b1;
    repeat (2) @(posedge CLOCK_50);
    for (int k = 0; k < 6; k++) begin
      b = 8'($urandom);
      @(negedge CLOCK_50);
      cnt_prev  = store_cnt;
      send_rx(b);
      n = 0;
      while (store_cnt == cnt_prev && n < bit_limit) begin
        @(negedge CLOCK_50);
        n++;
      end
      if (store_cnt == cnt_prev) begin
        abort_run("No store_valid pulse after an upload byte");
      end
      repeat (4) @(negedge CLOCK_50);
      check("store_valid count", store_cnt, cnt_prev + 1);
      check("store_data", store_seen, {8'h00, b});
      check("read_base", read_base, base_of(grey_mode, img_exp));
      check("hex0", hex0, seg_tab[img_exp[3:0]]);
      check("hex1", hex1, seg_tab[img_exp[7:4]]);
      check("hex2", hex2, seg_tab[b[3:0]]);
    end
    @(posedge CLOCK_50);
    upload_mode <= 1'b0;

    // Pixel unpacking in colour then grey
    for (int m = 0; m < 2; m++) begin
      set_grey(m[0]);
      for (int k = 0; k < 12; k++) begin
        @(posedge CLOCK_50);
        read_data <= buf_word_t'($urandom);
        @(negedge CLOCK_50);
        if (grey_mode) begin
          check("vga_r", vga_r, read_data[11:2]);
          check("vga_g", vga_g, read_data[11:2]);
          check("vga_b", vga_b, read_data[11:2]);
        end else begin
          check("vga_r", vga_r, {read_data[7:5], 7'h00});
          check("vga_g", vga_g, {read_data[4:2], 7'h00});
          check("vga_b", vga_b, {read_data[1:0], 8'h00});
        end
      end
    end
    repeat (3) @(negedge CLOCK_50);
    check("restart pulses", restart_cnt, exp_changes);

    // Full burst of burst_len bytes
    pix_base = pix_idx;
    pulse_key(1'b0);
    wait_hex4(seg_tab[1], "Upload flag never showed on hex4 after start");
    for (int k = 0; k < burst_len; k++) begin
      recv_tx(bit_limit, 1'b1, found, b);
      check("uart_txd byte", b, pix_mem[pix_base + k][11:4]);
      if (k < burst_len - 1) begin
        check("hex4", hex4, seg_tab[1]);
      end
    end
    wait_hex4(seg_tab[0], "Upload flag stayed on after the full burst");
    for (int k = 0; k < bit_limit; k++) begin
      @(negedge CLOCK_50);
      check("uart_txd idle", uart_txd, 1'b1);
    end
    check("pixel requests", pix_idx - pix_base, burst_len);

    // Stopped burst after 5 bytes
    pix_base = pix_idx;
    pulse_key(1'b0);
    wait_hex4(seg_tab[1], "Upload flag never showed on hex4 after restart");
    for (int k = 0; k < 5; k++) begin
      recv_tx(bit_limit, 1'b1, found, b);
      check("uart_txd byte", b, pix_mem[pix_base + k][11:4]);
    end
    pulse_key(1'b1);
    recv_tx(2 * clks_per_bit, 1'b0, found, b);
    if (found) begin
      check("uart_txd byte", b, pix_mem[pix_base + 5][11:4]);
      recv_tx(2 * clks_per_bit, 1'b0, found, b);
      if (found) abort_run("More than one byte sent after stop");
    end
    wait_hex4(seg_tab[0], "Upload flag stayed on after stop");
    check("restart pulses", restart_cnt, exp_changes);

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/camera_link_top.sv ====
// Camera board host link and display control
// UART receive and transmit, frame upload burst, image selection
// and the seven-segment status digits
`timescale 1ns/1ps
`default_nettype none

module camera_link_top
  import uart_pkg::*;
  import video_pkg::*;
#(
  parameter int frame_bytes = frame_bytes_default
) (
  input  wire       CLOCK_50,
  input  wire       DLY_RST_0,
  input  wire       uart_rxd,
  output logic      uart_txd,
  input  wire       start_n,
  input  wire       stop_n,
  input  wire       upload_mode,
  input  wire       grey_mode,
  input  tx_pixel_t tx_pixel,
  output logic      tx_pixel_req,
  output logic      store_valid,
  output buf_word_t store_data,
  input  buf_word_t read_data,
  output buf_addr_t read_base,
  output logic      disp_restart_n,
  output color_t    vga_r,
  output color_t    vga_g,
  output color_t    vga_b,
  output seg_t      hex0,
  output seg_t      hex1,
  output seg_t      hex2,
  output seg_t      hex3,
  output seg_t      hex4,
  output seg_t      hex5
);

  // ====================
  // Internal links
  // ====================
  uart_byte_t rx_byte;
  logic       rx_valid;
  logic       send;
  uart_byte_t send_byte;
  logic       tx_busy;
  logic       tx_done;
  logic       tx_active;
  img_idx_t   cur_img;
  uart_byte_t last_rx;

  // Host to board
  uart_rx u_uart_rx (
    .CLOCK_50 (CLOCK_50),
    .DLY_RST_0(DLY_RST_0),
    .rxd      (uart_rxd),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid)
  );

  // Board to host
  uart_tx u_uart_tx (
    .CLOCK_50 (CLOCK_50),
    .DLY_RST_0(DLY_RST_0),
    .send     (send),
    .send_byte(send_byte),
    .txd      (uart_txd),
    .tx_busy  (tx_busy),
    .tx_done  (tx_done)
  );

  frame_uploader #(
    .frame_bytes(frame_bytes)
  ) u_frame_uploader (
    .CLOCK_50    (CLOCK_50),
    .DLY_RST_0   (DLY_RST_0),
    .start_n     (start_n),
    .stop_n      (stop_n),
    .tx_pixel    (tx_pixel),
    .tx_busy     (tx_busy),
    .tx_done     (tx_done),
    .send        (send),
    .send_byte   (send_byte),
    .tx_pixel_req(tx_pixel_req),
    .tx_active   (tx_active)
  );

  image_select u_image_select (
    .CLOCK_50      (CLOCK_50),
    .DLY_RST_0     (DLY_RST_0),
    .rx_byte       (rx_byte),
    .rx_valid      (rx_valid),
    .upload_mode   (upload_mode),
    .grey_mode     (grey_mode),
    .read_data     (read_data),
    .cur_img       (cur_img),
    .last_rx       (last_rx),
    .store_valid   (store_valid),
    .store_data    (store_data),
    .read_base     (read_base),
    .disp_restart_n(disp_restart_n),
    .vga_r         (vga_r),
    .vga_g         (vga_g),
    .vga_b         (vga_b)
  );

  status_display u_status_display (
    .CLOCK_50 (CLOCK_50),
    .DLY_RST_0(DLY_RST_0),
    .cur_img  (cur_img),
    .last_rx  (last_rx),
    .tx_active(tx_active),
    .hex0     (hex0),
    .hex1     (hex1),
    .hex2     (hex2),
    .hex3     (hex3),
    .hex4     (hex4),
    .hex5     (hex5)
  );

endmodule

`default_nettype wire

// ==== verilog/frame_uploader.sv ====
// Frame upload control
// Start key opens a byte burst to the transmitter, one byte per pixel
// from its upper 8 bits, until frame_bytes are sent or stop is pressed
`timescale 1ns/1ps
`default_nettype none

module frame_uploader
  import uart_pkg::*;
  import video_pkg::*;
#(
  parameter int frame_bytes = frame_bytes_default
) (
  input  wire        CLOCK_50,
  input  wire        DLY_RST_0,
  input  wire        start_n,
  input  wire        stop_n,
  input  tx_pixel_t  tx_pixel,
  input  wire        tx_busy,
  input  wire        tx_done,
  output logic       send,
  output uart_byte_t send_byte,
  output logic       tx_pixel_req,
  output logic       tx_active
);

  frame_cnt_t byte_cnt;
  logic       frame_end;

  assign frame_end = (byte_cnt == frame_cnt_t'(frame_bytes));

  // Keys held low suppress sends, transmitter free or just finishing
  assign send = tx_active && start_n && stop_n && !frame_end &&
                (!tx_busy || tx_done);
  assign send_byte = tx_pixel[11:4];
  // Next pixel requested with every byte
  assign tx_pixel_req = send;

  // ====================
  // Burst state
  // ====================
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      tx_active <= 1'b0;
      byte_cnt  <= '0;
    end else if (!stop_n) begin
      // Stop wins over start
      tx_active <= 1'b0;
    end else if (!start_n) begin
      tx_active <= 1'b1;
      byte_cnt  <= '0;
    end else begin
      if (send) begin
        byte_cnt <= byte_cnt + 1'b1;
      end
      if (frame_end) begin
        tx_active <= 1'b0;
      end
    end
  end

  // Burst length bounded by frame size
  a_cnt_in_range: assert property (
    @(posedge CLOCK_50) disable iff (!DLY_RST_0) byte_cnt <= frame_cnt_t'(frame_bytes));

endmodule

`default_nettype wire

// ==== verilog/image_select.sv ====
// Received byte routing and display control
// Selects the stored image or forwards bytes to the frame buffer,
// forms the read base, the restart pulse and the unpacked RGB
`timescale 1ns/1ps
`default_nettype none

module image_select
  import uart_pkg::*;
  import video_pkg::*;
(
  input  wire        CLOCK_50,
  input  wire        DLY_RST_0,
  input  uart_byte_t rx_byte,
  input  wire        rx_valid,
  input  wire        upload_mode,
  input  wire        grey_mode,
  input  buf_word_t  read_data,
  output img_idx_t   cur_img,
  output uart_byte_t last_rx,
  output logic       store_valid,
  output buf_word_t  store_data,
  output buf_addr_t  read_base,
  output logic       disp_restart_n,
  output color_t     vga_r,
  output color_t     vga_g,
  output color_t     vga_b
);

  img_idx_t img_q;
  logic     grey_q;
  logic     disp_changed;

  // ====================
  // Byte routing
  // ====================
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      cur_img     <= '0;
      last_rx     <= '0;
      store_valid <= 1'b0;
    end else begin
      store_valid <= rx_valid && upload_mode;
      if (rx_valid) begin
        last_rx <= rx_byte;
        // Image index held while uploading
        if (!upload_mode) begin
          cur_img <= img_idx_t'(rx_byte);
        end
      end
    end
  end

  // Store word, zero extended
  always_ff @(posedge CLOCK_50) begin
    if (rx_valid && upload_mode) begin
      store_data <= buf_word_t'(rx_byte);
    end
  end

  // Stored images at fixed stride above store_base
  assign read_base = grey_mode ? live_base
                   : buf_addr_t'(store_base + image_stride * buf_addr_t'(cur_img));

  // ====================
  // Display restart
  // ====================
  // Previous image/mode pair
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      img_q          <= '0;
      grey_q         <= 1'b0;
      disp_restart_n <= 1'b1;
    end else begin
      img_q          <= cur_img;
      grey_q         <= grey_mode;
      // Low for one cycle per change
      disp_restart_n <= !disp_changed;
    end
  end

  assign disp_changed = ({cur_img, grey_mode} != {img_q, grey_q});

  // ====================
  // Pixel unpack
  // ====================
  // Grey: bits 11..2 on every channel; colour: 3-3-2 packed in the low byte
  assign vga_r = grey_mode ? read_data[11:2] : {read_data[7:5], 7'h00};
  assign vga_g = grey_mode ? read_data[11:2] : {read_data[4:2], 7'h00};
  assign vga_b = grey_mode ? read_data[11:2] : {read_data[1:0], 8'h00};

  // Same byte never selects and stores
  a_store_or_select: assert property (
    @(posedge CLOCK_50) disable iff (!DLY_RST_0) store_valid |-> $stable(cur_img));

endmodule

`default_nettype wire

// ==== verilog/status_display.sv ====
// Six-digit status display
// Image index, last received byte and upload flag as hex digits
`timescale 1ns/1ps
`default_nettype none

module status_display
  import uart_pkg::*;
  import video_pkg::*;
(
  input  wire        CLOCK_50,
  input  wire        DLY_RST_0,
  input  img_idx_t   cur_img,
  input  uart_byte_t last_rx,
  input  wire        tx_active,
  output seg_t       hex0,
  output seg_t       hex1,
  output seg_t       hex2,
  output seg_t       hex3,
  output seg_t       hex4,
  output seg_t       hex5
);

  // Active-low hex font, segment a in bit 0
  function automatic seg_t hex_to_seg(input logic [3:0] nib);
    seg_t seg;
    case (nib)
      4'h0: seg = 7'h40;
      4'h1: seg = 7'h79;
      4'h2: seg = 7'h24;
      4'h3: seg = 7'h30;
      4'h4: seg = 7'h19;
      4'h5: seg = 7'h12;
      4'h6: seg = 7'h02;
      4'h7: seg = 7'h78;
      4'h8: seg = 7'h00;
      4'h9: seg = 7'h10;
      4'hA: seg = 7'h08;
      4'hB: seg = 7'h03;
      4'hC: seg = 7'h46;
      4'hD: seg = 7'h21;
      4'hE: seg = 7'h06;
      default: seg = 7'h0E;
    endcase
    return seg;
  endfunction

  // ====================
  // Digit registers
  // ====================
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      hex0 <= hex_to_seg(4'h0);
      hex1 <= hex_to_seg(4'h0);
      hex2 <= hex_to_seg(4'h0);
      hex3 <= hex_to_seg(4'h0);
      hex4 <= hex_to_seg(4'h0);
      hex5 <= hex_to_seg(4'h0);
    end else begin
      // Image index
      hex0 <= hex_to_seg(cur_img[3:0]);
      hex1 <= hex_to_seg(cur_img[7:4]);
      // Last byte from host
      hex2 <= hex_to_seg(last_rx[3:0]);
      hex3 <= hex_to_seg(last_rx[7:4]);
      // Upload flag as 0 or 1
      hex4 <= hex_to_seg({3'b000, tx_active});
      hex5 <= hex_to_seg(4'h0);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/uart_pkg.sv ====
// Serial link constants for the host UART
// 8N1 framing at 115200 baud from the 50 MHz board clock
`default_nettype none

package uart_pkg;

  // ====================
  // Bit timing
  // ====================
  // 50 MHz / 115200
  localparam int clks_per_bit = 434;
  // Centre of the start bit
  localparam int half_bit = clks_per_bit / 2;
  // Data bits per character
  localparam int data_bits = 8;

  // Bit-time counter, holds up to clks_per_bit - 1
  typedef logic [8:0] baud_cnt_t;
  // One serial data byte
  typedef logic [7:0] uart_byte_t;

endpackage

`default_nettype wire

// ==== verilog/uart_rx.sv ====
// UART receiver, 8N1, LSB first
// Finds the start edge behind a two-flop synchronizer, samples each
// bit at its centre and strobes rx_valid once per good byte
`timescale 1ns/1ps
`default_nettype none

module uart_rx
  import uart_pkg::*;
(
  input  wire        CLOCK_50,
  input  wire        DLY_RST_0,
  input  wire        rxd,
  output uart_byte_t rx_byte,
  output logic       rx_valid
);

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_t;

  rx_state_t  state;
  baud_cnt_t  cnt;
  logic [2:0] bit_idx;
  logic [2:0] rxd_sr;
  uart_byte_t shift;
  logic       rxd_s;
  logic       fall;
  logic       half_end;
  logic       bit_end;
  logic       stop_ok;

  // ====================
  // Synchronizer
  // ====================
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      rxd_sr <= 3'b111;
    end else begin
      rxd_sr <= {rxd_sr[1:0], rxd};
    end
  end

  assign rxd_s = rxd_sr[1];
  // Start edge, high to low after sync
  assign fall = rxd_sr[2] & ~rxd_sr[1];
  assign half_end = (cnt == baud_cnt_t'(half_bit - 1));
  assign bit_end = (cnt == baud_cnt_t'(clks_per_bit - 1));
  // Stop bit must read high, else byte dropped
  assign stop_ok = (state == rx_stop) && bit_end && rxd_s;

  // ====================
  // Bit FSM
  // ====================
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      state    <= rx_idle;
      cnt      <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= stop_ok;
      case (state)
        rx_idle: begin
          cnt <= '0;
          if (fall) begin
            state <= rx_start;
          end
        end
        rx_start: begin
          if (half_end) begin
            cnt     <= '0;
            bit_idx <= '0;
            // Line back high mid start bit is a glitch
            state   <= rxd_s ? rx_idle : rx_data;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        rx_data: begin
          if (bit_end) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'(data_bits - 1)) begin
              state <= rx_stop;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        rx_stop: begin
          if (bit_end) begin
            cnt   <= '0;
            state <= rx_idle;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  // Shift in at bit centres, LSB arrives first
  always_ff @(posedge CLOCK_50) begin
    if (state == rx_data && bit_end) begin
      shift <= {rxd_s, shift[7:1]};
    end
    if (stop_ok) begin
      rx_byte <= shift;
    end
  end

  // One strobe per character, never back to back
  a_rx_valid_single: assert property (
    @(posedge CLOCK_50) disable iff (!DLY_RST_0) rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

// ==== verilog/uart_tx.sv ====
// UART transmitter, 8N1, LSB first
// Busy from send until the stop bit ends, done pulse on that last cycle
`timescale 1ns/1ps
`default_nettype none

module uart_tx
  import uart_pkg::*;
(
  input  wire        CLOCK_50,
  input  wire        DLY_RST_0,
  input  wire        send,
  input  uart_byte_t send_byte,
  output logic       txd,
  output logic       tx_busy,
  output logic       tx_done
);

  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop
  } tx_state_t;

  tx_state_t  state;
  baud_cnt_t  cnt;
  logic [2:0] bit_idx;
  uart_byte_t shift;
  logic       bit_end;
  logic       load;

  assign bit_end = (cnt == baud_cnt_t'(clks_per_bit - 1));
  assign tx_busy = (state != tx_idle);
  assign tx_done = (state == tx_stop) && bit_end;
  // New byte accepted when idle or right at the end of a stop bit
  assign load = send && (!tx_busy || tx_done);

  // ====================
  // Bit FSM
  // ====================
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      state   <= tx_idle;
      cnt     <= '0;
      bit_idx <= '0;
      txd     <= 1'b1;
    end else begin
      if (bit_end || state == tx_idle) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
      case (state)
        tx_idle: begin
          if (load) begin
            txd   <= 1'b0;
            state <= tx_start;
          end
        end
        tx_start: begin
          if (bit_end) begin
            txd     <= shift[0];
            bit_idx <= '0;
            state   <= tx_data;
          end
        end
        tx_data: begin
          if (bit_end) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'(data_bits - 1)) begin
              txd   <= 1'b1;
              state <= tx_stop;
            end else begin
              txd <= shift[0];
            end
          end
        end
        tx_stop: begin
          // Chain straight into the next start bit
          if (load) begin
            txd   <= 1'b0;
            state <= tx_start;
          end else if (bit_end) begin
            state <= tx_idle;
          end
        end
        default: state <= tx_idle;
      endcase
    end
  end

  // Data shifter, next bit always at shift[0]
  always_ff @(posedge CLOCK_50) begin
    if (load) begin
      shift <= send_byte;
    end else if (bit_end && (state == tx_start || state == tx_data)) begin
      shift <= {1'b0, shift[7:1]};
    end
  end

  // Upstream must respect busy, except in the done cycle
  a_send_not_busy: assert property (
    @(posedge CLOCK_50) disable iff (!DLY_RST_0) send |-> (!tx_busy || tx_done));

endmodule

`default_nettype wire

// ==== verilog/video_pkg.sv ====
// Frame-buffer, pixel and display types for the camera link
// Stored images sit above the live grey buffer at a fixed stride
`default_nettype none

package video_pkg;

  // ====================
  // Data widths
  // ====================
  // One frame-buffer word
  typedef logic [15:0] buf_word_t;
  // Raw camera pixel
  typedef logic [11:0] tx_pixel_t;
  // One VGA colour channel
  typedef logic [9:0] color_t;
  // Frame-buffer word address
  typedef logic [22:0] buf_addr_t;
  // Stored image number
  typedef logic [7:0] img_idx_t;
  // Active low, bit 0 is segment a
  typedef logic [6:0] seg_t;
  // Upload byte count
  typedef logic [19:0] frame_cnt_t;

  // ====================
  // Frame-buffer map
  // ====================
  // Live camera buffer, grey only
  localparam buf_addr_t live_base = 23'h000000;
  // First stored image
  localparam buf_addr_t store_base = 23'h100000;
  // 640 x 480 words per image
  localparam buf_addr_t image_stride = 23'h04B000;
  // One byte per pixel
  localparam int frame_bytes_default = 307200;

endpackage

`default_nettype wire
